// ==== Makefile ====
# Verilator flow for the memctrl project

VERILATOR ?= verilator
FILELIST  ?= memctrl.f
TB_TOP    ?= tb_memctrl
RTL_TOP   ?= memctrl
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== memctrl.f ====
memctrl_pkg.sv
memctrl_fifo.sv
memctrl_rd_path.sv
memctrl_wr_path.sv
memctrl.sv
tb_memctrl.sv

// ==== memctrl.sv ====
// Memory side assumed single-beat, full block width, incrementing bursts
// Reads complete in order, responses are forwarded unchecked

`timescale 1ns/1ps

module memctrl (
    input  logic                     aclk,
    input  logic                     aresetn,
    // Cache read address
    input  logic                     mst_arvalid,
    output logic                     mst_arready,
    input  memctrl_pkg::addr_t       mst_araddr,
    input  logic                     mst_arcache,
    input  memctrl_pkg::id_t         mst_arid,
    // Cache read completion
    output logic                     mst_rvalid,
    input  logic                     mst_rready,
    output memctrl_pkg::block_t      mst_rdata_blk,
    output memctrl_pkg::word_t       mst_rdata,
    output memctrl_pkg::addr_t       mst_raddr,
    output logic                     mst_rcache,
    output memctrl_pkg::id_t         mst_rid,
    output memctrl_pkg::resp_t       mst_rresp,
    // Cache write address
    input  logic                     mst_awvalid,
    output logic                     mst_awready,
    input  memctrl_pkg::addr_t       mst_awaddr,
    input  memctrl_pkg::id_t         mst_awid,
    // Cache write data
    input  logic                     mst_wvalid,
    output logic                     mst_wready,
    input  memctrl_pkg::word_t       mst_wdata,
    input  memctrl_pkg::word_strb_t  mst_wstrb,
    // Cache write response
    output logic                     mst_bvalid,
    input  logic                     mst_bready,
    output memctrl_pkg::id_t         mst_bid,
    output memctrl_pkg::resp_t       mst_bresp,
    // Memory read address
    output logic                     mem_arvalid,
    input  logic                     mem_arready,
    output memctrl_pkg::addr_t       mem_araddr,
    output memctrl_pkg::id_t         mem_arid,
    // Memory read data
    input  logic                     mem_rvalid,
    output logic                     mem_rready,
    input  memctrl_pkg::id_t         mem_rid,
    input  memctrl_pkg::resp_t       mem_rresp,
    input  memctrl_pkg::block_t      mem_rdata,
    // Memory write address
    output logic                     mem_awvalid,
    input  logic                     mem_awready,
    output memctrl_pkg::addr_t       mem_awaddr,
    output memctrl_pkg::id_t         mem_awid,
    // Memory write data
    output logic                     mem_wvalid,
    input  logic                     mem_wready,
    output memctrl_pkg::block_t      mem_wdata,
    output memctrl_pkg::block_strb_t mem_wstrb,
    // Memory write response
    input  logic                     mem_bvalid,
    output logic                     mem_bready,
    input  memctrl_pkg::id_t         mem_bid,
    input  memctrl_pkg::resp_t       mem_bresp
);

    ////////////////////////////////////////
    // Read chain
    ////////////////////////////////////////

    memctrl_rd_path u_rd_path (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .mst_arvalid   (mst_arvalid),
        .mst_arready   (mst_arready),
        .mst_araddr    (mst_araddr),
        .mst_arcache   (mst_arcache),
        .mst_arid      (mst_arid),
        .mst_rvalid    (mst_rvalid),
        .mst_rready    (mst_rready),
        .mst_rdata_blk (mst_rdata_blk),
        .mst_rdata     (mst_rdata),
        .mst_raddr     (mst_raddr),
        .mst_rcache    (mst_rcache),
        .mst_rid       (mst_rid),
        .mst_rresp     (mst_rresp),
        .mem_arvalid   (mem_arvalid),
        .mem_arready   (mem_arready),
        .mem_araddr    (mem_araddr),
        .mem_arid      (mem_arid),
        .mem_rvalid    (mem_rvalid),
        .mem_rready    (mem_rready),
        .mem_rid       (mem_rid),
        .mem_rresp     (mem_rresp),
        .mem_rdata     (mem_rdata)
    );

    ////////////////////////////////////////
    // Write chain
    ////////////////////////////////////////

    memctrl_wr_path u_wr_path (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .mst_awvalid (mst_awvalid),
        .mst_awready (mst_awready),
        .mst_awaddr  (mst_awaddr),
        .mst_awid    (mst_awid),
        .mst_wvalid  (mst_wvalid),
        .mst_wready  (mst_wready),
        .mst_wdata   (mst_wdata),
        .mst_wstrb   (mst_wstrb),
        .mst_bvalid  (mst_bvalid),
        .mst_bready  (mst_bready),
        .mst_bid     (mst_bid),
        .mst_bresp   (mst_bresp),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_awaddr  (mem_awaddr),
        .mem_awid    (mem_awid),
        .mem_wvalid  (mem_wvalid),
        .mem_wready  (mem_wready),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_bvalid  (mem_bvalid),
        .mem_bready  (mem_bready),
        .mem_bid     (mem_bid),
        .mem_bresp   (mem_bresp)
    );

endmodule

// ==== memctrl_fifo.sv ====
// Push while full and pull while empty are ignored
// Head entry is visible on data_out without a read cycle

`timescale 1ns/1ps

module memctrl_fifo #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     push,
    input  payload_t data_in,
    input  logic     pull,
    output payload_t data_out,
    output logic     full,
    output logic     empty,
    output logic     aempty
);

    import memctrl_pkg::*;

    // Storage, payload only so no reset
    payload_t buffer [ostd_num];

    logic [tag_w-1:0] wr_ptr;
    logic [tag_w-1:0] rd_ptr;
    logic [tag_w:0] count;
    logic wr_en;
    logic rd_en;

    assign wr_en = push && !full;
    assign rd_en = pull && !empty;

    ////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // Wrap at the last slot
            if (wr_en) begin
                wr_ptr <= (wr_ptr == tag_w'(ostd_num - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == tag_w'(ostd_num - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Level moves only when one side is active alone
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            buffer[wr_ptr] <= data_in;
        end
    end

    ////////////////////////////////////////
    // Status and head
    ////////////////////////////////////////

    assign data_out = buffer[rd_ptr];
    assign full = (count == (tag_w + 1)'(ostd_num));
    assign empty = (count == '0);
    // Exactly one entry left
    assign aempty = (count == (tag_w + 1)'(1));

endmodule

// ==== memctrl_pkg.sv ====
// Widths assume one memory beat holds exactly one cache block
// Block and word sizes must stay powers of two

package memctrl_pkg;

    ////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////

    // Cache word and address
    localparam int xlen = 32;
    localparam int addr_w = 16;
    localparam int id_w = 4;

    // One block per memory beat
    localparam int block_w = 128;

    // Outstanding reads, also the depth of the write offset queue
    localparam int ostd_num = 4;
    localparam int tag_w = $clog2(ostd_num);

    // Word position inside a block
    localparam int lane_num = block_w / xlen;
    localparam int offset_w = 2;
    localparam int offset_lsb = 2;

    // Byte strobes
    localparam int word_strb_w = xlen / 8;
    localparam int block_strb_w = block_w / 8;

    ////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [id_w-1:0] id_t;
    typedef logic [xlen-1:0] word_t;
    typedef logic [block_w-1:0] block_t;
    typedef logic [offset_w-1:0] offset_t;
    typedef logic [word_strb_w-1:0] word_strb_t;
    typedef logic [block_strb_w-1:0] block_strb_t;
    typedef logic [1:0] resp_t;

    // Read tracking entry, cacheable bit above the address
    typedef struct packed {
        logic cacheable;
        addr_t addr;
    } rd_tag_t;

endpackage

// ==== memctrl_rd_path.sv ====
// Memory must answer reads in issue order, one full block per beat
// At most ostd_num reads are tracked, more are held off on mst_arready

`timescale 1ns/1ps

module memctrl_rd_path (
    input  logic                 aclk,
    input  logic                 aresetn,
    // Cache read address
    input  logic                 mst_arvalid,
    output logic                 mst_arready,
    input  memctrl_pkg::addr_t   mst_araddr,
    input  logic                 mst_arcache,
    input  memctrl_pkg::id_t     mst_arid,
    // Cache read completion
    output logic                 mst_rvalid,
    input  logic                 mst_rready,
    output memctrl_pkg::block_t  mst_rdata_blk,
    output memctrl_pkg::word_t   mst_rdata,
    output memctrl_pkg::addr_t   mst_raddr,
    output logic                 mst_rcache,
    output memctrl_pkg::id_t     mst_rid,
    output memctrl_pkg::resp_t   mst_rresp,
    // Memory read address
    output logic                 mem_arvalid,
    input  logic                 mem_arready,
    output memctrl_pkg::addr_t   mem_araddr,
    output memctrl_pkg::id_t     mem_arid,
    // Memory read data
    input  logic                 mem_rvalid,
    output logic                 mem_rready,
    input  memctrl_pkg::id_t     mem_rid,
    input  memctrl_pkg::resp_t   mem_rresp,
    input  memctrl_pkg::block_t  mem_rdata
);

    import memctrl_pkg::*;

    rd_tag_t tag_in;
    rd_tag_t tag_head;
    logic tag_full;
    logic tag_empty;
    offset_t roffset;

    ////////////////////////////////////////
    // Address forwarding
    ////////////////////////////////////////

    // Request reaches memory only when a tracking slot is free
    assign mem_arvalid = mst_arvalid && !tag_full;
    assign mst_arready = mem_arready && !tag_full;
    assign mem_araddr = mst_araddr;
    assign mem_arid = mst_arid;

    assign tag_in.addr = mst_araddr;
    assign tag_in.cacheable = mst_arcache;

    // Tag pushed on cache handshake, popped on memory data beat
    memctrl_fifo #(
        .payload_t (rd_tag_t)
    ) rd_tag_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (mst_arvalid && mst_arready),
        .data_in  (tag_in),
        .pull     (mem_rvalid && mem_rready),
        .data_out (tag_head),
        .full     (tag_full),
        .empty    (tag_empty),
        .aempty   ()
    );

    ////////////////////////////////////////
    // Completion
    ////////////////////////////////////////

    // Word index of the oldest outstanding read
    assign roffset = tag_head.addr[offset_lsb +: offset_w];

    assign mst_rvalid = mem_rvalid;
    assign mem_rready = mst_rready;
    assign mst_rid = mem_rid;
    assign mst_rresp = mem_rresp;
    assign mst_rdata_blk = mem_rdata;
    assign mst_rdata = mem_rdata[xlen*roffset +: xlen];
    assign mst_raddr = tag_head.addr;
    // Stale head content must not look cacheable
    assign mst_rcache = tag_empty ? 1'b0 : tag_head.cacheable;

endmodule

// ==== memctrl_wr_path.sv ====
// Each write data beat must come with or after its own address, in order
// Single-beat writes only, the word is replicated over the whole block

`timescale 1ns/1ps

module memctrl_wr_path (
    input  logic                     aclk,
    input  logic                     aresetn,
    // Cache write address
    input  logic                     mst_awvalid,
    output logic                     mst_awready,
    input  memctrl_pkg::addr_t       mst_awaddr,
    input  memctrl_pkg::id_t         mst_awid,
    // Cache write data
    input  logic                     mst_wvalid,
    output logic                     mst_wready,
    input  memctrl_pkg::word_t       mst_wdata,
    input  memctrl_pkg::word_strb_t  mst_wstrb,
    // Cache write response
    output logic                     mst_bvalid,
    input  logic                     mst_bready,
    output memctrl_pkg::id_t         mst_bid,
    output memctrl_pkg::resp_t       mst_bresp,
    // Memory write address
    output logic                     mem_awvalid,
    input  logic                     mem_awready,
    output memctrl_pkg::addr_t       mem_awaddr,
    output memctrl_pkg::id_t         mem_awid,
    // Memory write data
    output logic                     mem_wvalid,
    input  logic                     mem_wready,
    output memctrl_pkg::block_t      mem_wdata,
    output memctrl_pkg::block_strb_t mem_wstrb,
    // Memory write response
    input  logic                     mem_bvalid,
    output logic                     mem_bready,
    input  memctrl_pkg::id_t         mem_bid,
    input  memctrl_pkg::resp_t       mem_bresp
);

    import memctrl_pkg::*;

    logic aw_hs;
    logic w_hs;
    logic off_full;
    logic off_aempty;
    logic push_off;
    logic pull_off;
    logic off_pending;
    offset_t addr_off;
    offset_t head_off;
    offset_t lane;

    ////////////////////////////////////////
    // Address and data forwarding
    ////////////////////////////////////////

    // New addresses wait for room in the offset queue
    assign mem_awvalid = mst_awvalid && !off_full;
    assign mst_awready = mem_awready && !off_full;
    assign mem_awaddr = mst_awaddr;
    assign mem_awid = mst_awid;

    // A full queue only drains through data beats, so they are
    // never held back by it
    assign mem_wvalid = mst_wvalid;
    assign mst_wready = mem_wready;

    assign aw_hs = mem_awvalid && mem_awready;
    assign w_hs = mem_wvalid && mem_wready;

    ////////////////////////////////////////
    // Lane placement
    ////////////////////////////////////////

    assign addr_off = mst_awaddr[offset_lsb +: offset_w];

    // Queued offsets belong to older addresses, served first
    assign lane = off_pending ? head_off : addr_off;

    // Same word in every lane, memory picks it by strobe
    assign mem_wdata = {lane_num{mst_wdata}};

    always_comb begin
        mem_wstrb = '0;
        mem_wstrb[lane*word_strb_w +: word_strb_w] = mst_wstrb;
    end

    ////////////////////////////////////////
    // Offset queueing
    ////////////////////////////////////////

    // Address accepted but its beat not consumed directly this cycle
    assign push_off = aw_hs && (!w_hs || off_pending);
    // Beat consumed its lane from the queue head
    assign pull_off = w_hs && off_pending;

    memctrl_fifo #(
        .payload_t (offset_t)
    ) wr_off_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (push_off),
        .data_in  (addr_off),
        .pull     (pull_off),
        .data_out (head_off),
        .full     (off_full),
        .empty    (),
        .aempty   (off_aempty)
    );

    // Data channel running behind its addresses
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            off_pending <= 1'b0;
        end else if (push_off) begin
            off_pending <= 1'b1;
        end else if (pull_off && off_aempty) begin
            // Last queued offset used, nothing new behind it
            off_pending <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Write response
    ////////////////////////////////////////

    assign mst_bvalid = mem_bvalid;
    assign mem_bready = mst_bready;
    assign mst_bid = mem_bid;
    assign mst_bresp = mem_bresp;

endmodule

// ==== tb_memctrl.sv ====
// Memory model holds 64 blocks picked by address bits 9:4, answers reads in order
// Write beats are never driven ahead of their own address

`timescale 1ns/1ps

module tb_memctrl;

    import memctrl_pkg::*;

    localparam int op_rd = 0;
    localparam int op_wr = 1;
    localparam int op_rdseq = 2;
    localparam int op_wrseq = 3;
    localparam int stall_none = 0;
    localparam int stall_r = 1;
    localparam int stall_w = 2;
    localparam int stall_ar = 3;
    localparam int num_tests = 8;
    localparam int max_cycles = num_tests * 64 + 200;
    localparam int blk_lsb = 4;

    logic aclk;
    logic aresetn;
    logic mst_arvalid, mst_arready, mst_arcache, mst_rvalid, mst_rready, mst_rcache;
    addr_t mst_araddr, mst_raddr, mst_awaddr, mem_araddr, mem_awaddr;
    id_t mst_arid, mst_rid, mst_awid, mst_bid, mem_arid, mem_awid;
    block_t mst_rdata_blk, mem_wdata;
    word_t mst_rdata, mst_wdata;
    resp_t mst_rresp, mst_bresp;
    logic mst_awvalid, mst_awready, mst_wvalid, mst_wready, mst_bvalid, mst_bready;
    word_strb_t mst_wstrb;
    logic mem_arvalid, mem_rready, mem_awvalid, mem_wvalid, mem_bready;
    block_strb_t mem_wstrb;
    // Memory side inputs, driven by the model only
    logic mem_arready = 1'b0;
    logic mem_rvalid = 1'b0;
    logic mem_wready = 1'b0;
    logic mem_awready = 1'b0;
    logic mem_bvalid = 1'b0;
    id_t mem_rid = '0;
    id_t mem_bid = '0;
    resp_t mem_rresp = '0;
    resp_t mem_bresp = '0;
    block_t mem_rdata = '0;

    memctrl DUT (.*);

    ////////////////////////////////////////
    // Stimulus table and bookkeeping
    ////////////////////////////////////////

    int t_op [num_tests];
    addr_t t_addr [num_tests];
    word_t t_data [num_tests];
    word_strb_t t_strb [num_tests];
    logic t_cache [num_tests];
    int t_stall [num_tests];
    int n_entries = 0;

    block_t shadow [64];
    addr_t exp_addr_q [$];
    logic exp_cache_q [$];
    id_t exp_id_q [$];
    int errors = 0;
    int checks = 0;
    int r_count = 0;
    int cycles = 0;

    // Model controls, set by the tests
    logic hold_r = 1'b0;
    logic hold_w = 1'b0;
    logic ar_random = 1'b0;

    // Fill word from its byte address, inverse copy above
    function automatic word_t fill_word(input int blk, input int w);
        logic [15:0] a;
        a = 16'(blk * 16 + w * 4);
        return {~a, a};
    endfunction

    function automatic string op_name(input int op);
        case (op)
            op_rd: return "read";
            op_wr: return "write";
            op_rdseq: return "read sequence";
            default: return "write sequence";
        endcase
    endfunction

    task automatic add_entry(input int op, input addr_t addr, input word_t data,
                             input word_strb_t strb, input logic cache, input int stall);
        t_op[n_entries] = op;
        t_addr[n_entries] = addr;
        t_data[n_entries] = data;
        t_strb[n_entries] = strb;
        t_cache[n_entries] = cache;
        t_stall[n_entries] = stall;
        n_entries++;
    endtask

    // Bytes of the addressed word replaced where the strobe is set
    task automatic apply_write(input addr_t addr, input word_t data, input word_strb_t strb);
        for (int b = 0; b < word_strb_w; b++) begin
            if (strb[b]) begin
                shadow[addr[blk_lsb +: 6]][addr[offset_lsb +: offset_w] * xlen + b * 8 +: 8] =
                    data[b * 8 +: 8];
            end
        end
    endtask

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////

    integer seed = 32'hfa3c;
    addr_t ar_addr_q [$];
    id_t ar_id_q [$];
    addr_t aw_addr_q [$];
    id_t aw_id_q [$];
    id_t b_id_q [$];
    int ar_rd_idx = 0;
    int aw_rd_idx = 0;
    int b_rd_idx = 0;
    int r_hs_cnt = 0;
    int r_done_cnt = 0;
    int b_hs_cnt = 0;
    int b_done_cnt = 0;
    int r_wait = 0;
    int mem_errors = 0;
    int mem_checks = 0;
    logic [31:0] rnd;
    addr_t wr_addr;
    addr_t rd_addr;
    block_strb_t wr_exp_strb;
    block_t mem_arr [64];

    // Handshakes are taken on the rising edge
    always @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < 64; i++) begin
                for (int w = 0; w < lane_num; w++) begin
                    mem_arr[i][w * xlen +: xlen] = fill_word(i, w);
                end
            end
        end else begin
            if (mem_arvalid && mem_arready) begin
                ar_addr_q.push_back(mem_araddr);
                ar_id_q.push_back(mem_arid);
            end
            if (mem_awvalid && mem_awready) begin
                aw_addr_q.push_back(mem_awaddr);
                aw_id_q.push_back(mem_awid);
            end
            if (mem_wvalid && mem_wready) begin
                if (aw_rd_idx >= aw_addr_q.size()) begin
                    $display("Write beat reached memory with no address in front of it");
                    mem_errors++;
                end else begin
                    // Beat belongs to the oldest unserved address
                    wr_addr = aw_addr_q[aw_rd_idx];
                    b_id_q.push_back(aw_id_q[aw_rd_idx]);
                    aw_rd_idx++;
                    wr_exp_strb = block_strb_t'(mst_wstrb)
                        << (wr_addr[offset_lsb +: offset_w] * word_strb_w);
                    mem_checks += 2;
                    if (mem_wdata !== {lane_num{mst_wdata}}) begin
                        $display("MISMATCH @%0t: mem_wdata %h not replicated %h",
                                 $time, mem_wdata, mst_wdata);
                        mem_errors++;
                    end
                    if (mem_wstrb !== wr_exp_strb) begin
                        $display("MISMATCH @%0t: mem_wstrb for %h got %h expected %h",
                                 $time, wr_addr, mem_wstrb, wr_exp_strb);
                        mem_errors++;
                    end
                    for (int b = 0; b < block_strb_w; b++) begin
                        if (mem_wstrb[b]) begin
                            mem_arr[wr_addr[blk_lsb +: 6]][b * 8 +: 8] = mem_wdata[b * 8 +: 8];
                        end
                    end
                end
            end
            if (mem_rvalid && mem_rready) begin
                r_hs_cnt++;
            end
            if (mem_bvalid && mem_bready) begin
                b_hs_cnt++;
            end
        end
    end

    // Model outputs change on the falling edge
    always @(negedge aclk) begin
        if (aresetn) begin
            rnd = $random(seed);
            mem_arready = ar_random ? rnd[0] : 1'b1;
            mem_awready = 1'b1;
            mem_wready = !hold_w;
            // Retire the beat taken at the last rising edge
            if (r_hs_cnt != r_done_cnt) begin
                r_done_cnt = r_hs_cnt;
                mem_rvalid = 1'b0;
                r_wait = $random(seed) & 3;
            end
            if (!mem_rvalid && ar_rd_idx < ar_addr_q.size() && !hold_r) begin
                if (r_wait == 0) begin
                    rd_addr = ar_addr_q[ar_rd_idx];
                    mem_rid = ar_id_q[ar_rd_idx];
                    mem_rdata = mem_arr[rd_addr[blk_lsb +: 6]];
                    // Response code varies with the block number
                    mem_rresp = rd_addr[blk_lsb +: 2];
                    mem_rvalid = 1'b1;
                    ar_rd_idx++;
                end else begin
                    r_wait--;
                end
            end
            if (b_hs_cnt != b_done_cnt) begin
                b_done_cnt = b_hs_cnt;
                mem_bvalid = 1'b0;
            end
            if (!mem_bvalid && b_rd_idx < b_id_q.size()) begin
                mem_bid = b_id_q[b_rd_idx];
                mem_bresp = 2'b00;
                mem_bvalid = 1'b1;
                b_rd_idx++;
            end
        end
    end

    ////////////////////////////////////////
    // Cache side channel tasks
    ////////////////////////////////////////

    task automatic send_ar(input addr_t addr, input logic cache, input id_t id);
        mst_arvalid = 1'b1;
        mst_araddr = addr;
        mst_arcache = cache;
        mst_arid = id;
        @(posedge aclk);
        while (!mst_arready) begin
            @(posedge aclk);
        end
        exp_addr_q.push_back(addr);
        exp_cache_q.push_back(cache);
        exp_id_q.push_back(id);
        @(negedge aclk);
        mst_arvalid = 1'b0;
    endtask

    // Read beyond the tracking depth, blocked until a response drains one
    task automatic read_past_limit(input addr_t addr, input logic cache, input id_t id);
        int seen;
        mst_arvalid = 1'b1;
        mst_araddr = addr;
        mst_arcache = cache;
        mst_arid = id;
        repeat (10) begin
            @(posedge aclk);
            checks++;
            if (mst_arready) begin
                $display("MISMATCH @%0t: mst_arready high with %0d reads outstanding",
                         $time, ostd_num);
                errors++;
            end
        end
        @(negedge aclk);
        seen = r_count;
        hold_r = 1'b0;
        send_ar(addr, cache, id);
        checks++;
        if (r_count == seen) begin
            $display("MISMATCH @%0t: extra read accepted before any response", $time);
            errors++;
        end
    endtask

    task automatic recv_r();
        addr_t a;
        block_t blk;
        word_t w;
        @(posedge aclk);
        while (!mst_rvalid) begin
            @(posedge aclk);
        end
        r_count++;
        if (exp_addr_q.size() == 0) begin
            $display("Read data arrived with no read outstanding");
            errors++;
        end else begin
            a = exp_addr_q.pop_front();
            blk = shadow[a[blk_lsb +: 6]];
            w = blk[a[offset_lsb +: offset_w] * xlen +: xlen];
            checks += 6;
            if (mst_rdata_blk !== blk) begin
                $display("MISMATCH @%0t: rdata_blk for %h got %h expected %h",
                         $time, a, mst_rdata_blk, blk);
                errors++;
            end
            if (mst_rdata !== w) begin
                $display("MISMATCH @%0t: rdata for %h got %h expected %h",
                         $time, a, mst_rdata, w);
                errors++;
            end
            if (mst_raddr !== a) begin
                $display("MISMATCH @%0t: raddr got %h expected %h", $time, mst_raddr, a);
                errors++;
            end
            if (mst_rcache !== exp_cache_q.pop_front()) begin
                $display("MISMATCH @%0t: rcache wrong for %h", $time, a);
                errors++;
            end
            if (mst_rid !== exp_id_q.pop_front()) begin
                $display("MISMATCH @%0t: rid %h wrong for %h", $time, mst_rid, a);
                errors++;
            end
            if (mst_rresp !== resp_t'(a[blk_lsb +: 2])) begin
                $display("MISMATCH @%0t: rresp %b expected %b", $time, mst_rresp,
                         a[blk_lsb +: 2]);
                errors++;
            end
        end
        // Next request goes out on the falling edge
        @(negedge aclk);
    endtask

    task automatic send_aw(input addr_t addr, input id_t id);
        mst_awvalid = 1'b1;
        mst_awaddr = addr;
        mst_awid = id;
        @(posedge aclk);
        while (!mst_awready) begin
            @(posedge aclk);
        end
        @(negedge aclk);
        mst_awvalid = 1'b0;
    endtask

    task automatic send_w(input word_t data, input word_strb_t strb);
        mst_wvalid = 1'b1;
        mst_wdata = data;
        mst_wstrb = strb;
        @(posedge aclk);
        while (!mst_wready) begin
            @(posedge aclk);
        end
        @(negedge aclk);
        mst_wvalid = 1'b0;
    endtask

    task automatic recv_b(input id_t id);
        @(posedge aclk);
        while (!mst_bvalid) begin
            @(posedge aclk);
        end
        checks += 2;
        if (mst_bid !== id) begin
            $display("MISMATCH @%0t: bid got %h expected %h", $time, mst_bid, id);
            errors++;
        end
        if (mst_bresp !== 2'b00) begin
            $display("MISMATCH @%0t: bresp %b expected OKAY", $time, mst_bresp);
            errors++;
        end
        @(negedge aclk);
    endtask

    ////////////////////////////////////////
    // Test kinds
    ////////////////////////////////////////

    task automatic run_read(input int i);
        send_ar(t_addr[i], t_cache[i], id_t'(i));
        recv_r();
    endtask

    // Single beat with its address, then B and a read-back of the block
    task automatic run_write(input int i);
        fork
            send_aw(t_addr[i], id_t'(i));
            send_w(t_data[i], t_strb[i]);
            recv_b(id_t'(i));
        join
        apply_write(t_addr[i], t_data[i], t_strb[i]);
        send_ar(t_addr[i], 1'b0, 4'hf);
        recv_r();
    endtask

    // Back-to-back reads, one past the depth when responses are held
    task automatic run_read_seq(input int i);
        int n;
        n = (t_stall[i] == stall_r) ? ostd_num + 1 : ostd_num;
        hold_r = (t_stall[i] == stall_r);
        ar_random = (t_stall[i] == stall_ar);
        @(negedge aclk);
        fork
            begin
                for (int k = 0; k < n; k++) begin
                    if (k < ostd_num) begin
                        send_ar(t_addr[i] + addr_t'(k * 'h24), t_cache[i] ^ k[0], id_t'(k));
                    end else begin
                        read_past_limit(t_addr[i] + addr_t'(k * 'h24), t_cache[i], id_t'(k));
                    end
                end
            end
            begin
                for (int k = 0; k < n; k++) begin
                    recv_r();
                end
            end
        join
        ar_random = 1'b0;
    endtask

    // Addresses run ahead while the memory data channel is stalled
    task automatic run_write_seq(input int i);
        hold_w = (t_stall[i] == stall_w);
        @(negedge aclk);
        fork
            begin
                for (int k = 0; k < 3; k++) begin
                    send_aw(t_addr[i] + addr_t'(k * 'h14), id_t'(8 + k));
                end
                repeat (3) @(negedge aclk);
                hold_w = 1'b0;
            end
            begin
                for (int k = 0; k < 3; k++) begin
                    send_w(t_data[i] + word_t'(k), t_strb[i]);
                end
            end
            begin
                for (int k = 0; k < 3; k++) begin
                    recv_b(id_t'(8 + k));
                end
            end
        join
        for (int k = 0; k < 3; k++) begin
            apply_write(t_addr[i] + addr_t'(k * 'h14), t_data[i] + word_t'(k), t_strb[i]);
            send_ar(t_addr[i] + addr_t'(k * 'h14), 1'b1, id_t'(k));
            recv_r();
        end
    endtask

    ////////////////////////////////////////
    // Clock, timeout and main sequence
    ////////////////////////////////////////

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("Timeout, the run did not finish within %0d cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int errs_before;
        aresetn = 1'b0;
        mst_arvalid = 1'b0;
        mst_araddr = '0;
        mst_arcache = 1'b0;
        mst_arid = '0;
        mst_rready = 1'b1;
        mst_awvalid = 1'b0;
        mst_awaddr = '0;
        mst_awid = '0;
        mst_wvalid = 1'b0;
        mst_wdata = '0;
        mst_wstrb = '0;
        mst_bready = 1'b1;
        for (int i = 0; i < 64; i++) begin
            for (int w = 0; w < lane_num; w++) begin
                shadow[i][w * xlen +: xlen] = fill_word(i, w);
            end
        end
        // op, address, data, strobe, cacheable, stall mode
        add_entry(op_rd, 16'h0014, 32'h0, 4'h0, 1'b1, stall_none);
        add_entry(op_wr, 16'h0028, 32'hdeadbeef, 4'b1111, 1'b0, stall_none);
        add_entry(op_wr, 16'h003c, 32'h12345678, 4'b0101, 1'b0, stall_none);
        add_entry(op_rdseq, 16'h0044, 32'h0, 4'h0, 1'b1, stall_none);
        add_entry(op_rdseq, 16'h0100, 32'h0, 4'h0, 1'b0, stall_ar);
        add_entry(op_rdseq, 16'h0080, 32'h0, 4'h0, 1'b1, stall_r);
        add_entry(op_wrseq, 16'h0050, 32'hcafe0001, 4'b0011, 1'b0, stall_w);
        add_entry(op_rd, 16'h0058, 32'h0, 4'h0, 1'b0, stall_none);
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        repeat (2) @(negedge aclk);
        for (int i = 0; i < n_entries; i++) begin
            errs_before = errors + mem_errors;
            case (t_op[i])
                op_rd: run_read(i);
                op_wr: run_write(i);
                op_rdseq: run_read_seq(i);
                default: run_write_seq(i);
            endcase
            $display("Test %0d %s finished with %0d errors", i, op_name(t_op[i]),
                     errors + mem_errors - errs_before);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", n_entries,
                 checks + mem_checks, errors + mem_errors);
        if (errors + mem_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
